// ==== design/cpu_board_pkg.sv ====
//**********************************************************
// cpu board package
// widths, bus structs and address map of the two-CPU board
//**********************************************************
package cpu_board_pkg;

	// widths with a meaning
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [14:0] rom_addr_t;
	typedef logic [12:0] sram_addr_t;
	// decoded target, follows a read down the pipeline
	typedef logic [1:0]  tgt_t;

	// one cpu bus access, single-cycle strobe
	typedef struct packed {
		logic  strobe;
		logic  rd;
		addr_t addr;
		data_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic  valid;
		data_t rdata;
	} cpu_rsp_t;

	// rom download, cs[0] main pair, cs[1] sub pair
	// addr[15] picks the banked rom
	typedef struct packed {
		logic        wr;
		logic [1:0]  cs;
		logic [15:0] addr;
		data_t       data;
	} rom_load_t;

	// one-hot, active high
	typedef struct packed {
		logic map;
		logic back1;
		logic back2;
		logic obj;
		logic io;
		logic pl;
	} periph_sel_t;

	typedef struct packed {
		periph_sel_t sel;
		logic        rd;
		logic [14:0] addr;
		data_t       wdata;
	} ext_bus_t;

	// active low lines into the main cpu
	typedef struct packed {
		logic nmi_n;
		logic irq_n;
		logic firq_n;
	} main_irq_t;

	//**********************************************************
	// constants
	//**********************************************************
	// undriven bus reads back as all ones
	localparam data_t BUS_IDLE         = 8'hFF;
	localparam int    SHARED_RAM_WORDS = 8192;
	localparam int    ROM_WORDS        = 32768;

	// target codes
	localparam tgt_t TGT_SHM    = 2'd0;
	localparam tgt_t TGT_EXT    = 2'd1;
	localparam tgt_t TGT_BANKED = 2'd2;
	localparam tgt_t TGT_FIXED  = 2'd3;

	// main cpu map
	localparam addr_t SHARED_TOP  = 16'h1FFF;
	localparam addr_t MAP_BASE    = 16'h2000;
	localparam addr_t BACK1_BASE  = 16'h2800;
	localparam addr_t BACK2_BASE  = 16'h3000;
	localparam addr_t OBJ_BASE    = 16'h3800;
	localparam addr_t IO_BASE     = 16'h3A00;
	localparam addr_t PL_BASE     = 16'h3C00;
	localparam addr_t BANKED_BASE = 16'h4000;
	localparam addr_t FIXED_BASE  = 16'h8000;

	// sub cpu write-only windows, 2K each
	localparam addr_t SUB_MAIN_IRQ_BASE = 16'h2000;
	localparam addr_t SUB_IRQ_CLR_BASE  = 16'h2800;
	localparam addr_t SUB_BANK_BASE     = 16'h3000;
	localparam addr_t SUB_WIN_SIZE      = 16'h0800;

endpackage

// ==== design/interrupt_ctrl.sv ====
`timescale 1ns/1ps
//**********************************************************
// interrupt latches between the cpus and from the video side
// main nmi/irq/firq and sub irq, set by events, cleared by acks
//**********************************************************
module interrupt_ctrl (
	input  logic                     clk,
	input  logic                     RSTn,
	input  logic                     vblank,
	input  logic                     ims,
	input  logic                     nmi_ack,
	input  logic                     irq_ack,
	input  logic                     firq_ack,
	input  logic                     main_irq_set,
	input  logic                     sub_irq_set,
	input  logic                     sub_irq_clr,
	output cpu_board_pkg::main_irq_t main_irq,
	output logic                     sub_irq_n
);

	// level samples, bit 0 vblank, bit 1 ims
	logic [1:0] lvl_q;
	logic [1:0] lvl_prev;
	logic [1:0] rise;
	// sampled set strobes, bit 0 main irq, bit 1 sub irq
	logic [1:0] stb_set_q;
	// sampled clears, one per latch
	logic [3:0] clr_q;
	logic [3:0] set_v;
	// pending latches
	// 0 nmi, 1 irq, 2 firq, 3 sub irq
	logic [3:0] pend;

	// rising edges seen one edge after the sample
	assign rise  = lvl_q & ~lvl_prev;
	assign set_v = {stb_set_q[1], rise[1], stb_set_q[0], rise[0]};

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			lvl_q     <= '0;
			lvl_prev  <= '0;
			stb_set_q <= '0;
			clr_q     <= '0;
			pend      <= '0;
		end else begin
			lvl_q     <= {ims, vblank};
			lvl_prev  <= lvl_q;
			stb_set_q <= {sub_irq_set, main_irq_set};
			clr_q     <= {sub_irq_clr, firq_ack, irq_ack, nmi_ack};
			// clear wins over a set in the same cycle
			pend      <= (pend | set_v) & ~clr_q;
		end
	end

	// lines are low while pending
	assign main_irq  = '{nmi_n: ~pend[0], irq_n: ~pend[1], firq_n: ~pend[2]};
	assign sub_irq_n = ~pend[3];

endmodule

// ==== design/banked_rom.sv ====
`timescale 1ns/1ps
//**********************************************************
// rom pair of one cpu
// fixed 32K plus banked 32K, loadable, synchronous reads
//**********************************************************
module banked_rom #(
	parameter int LOAD_CS = 0
) (
	input  logic                     clk,
	input  cpu_board_pkg::rom_load_t rom_load,
	input  cpu_board_pkg::rom_addr_t fixed_addr,
	input  cpu_board_pkg::rom_addr_t banked_addr,
	output cpu_board_pkg::data_t     fixed_data,
	output cpu_board_pkg::data_t     banked_data
);
	import cpu_board_pkg::*;

	data_t     fixed_mem  [ROM_WORDS];
	data_t     banked_mem [ROM_WORDS];
	rom_addr_t load_addr;
	logic      load_en;

	// load port answers only to its own cs bit
	assign load_addr = rom_load.addr[14:0];
	assign load_en   = rom_load.wr && rom_load.cs[LOAD_CS];

	// lower half of the load space
	always_ff @(posedge clk) begin
		if (load_en && !rom_load.addr[15])
			fixed_mem[load_addr] <= rom_load.data;
		fixed_data <= fixed_mem[fixed_addr];
	end

	// upper half, two 16K banks
	always_ff @(posedge clk) begin
		if (load_en && rom_load.addr[15])
			banked_mem[load_addr] <= rom_load.data;
		banked_data <= banked_mem[banked_addr];
	end

endmodule

// ==== design/main_bus_ctrl.sv ====
`timescale 1ns/1ps
//**********************************************************
// main cpu bus control
// decode, peripheral bus, rom addressing and read return
//**********************************************************
module main_bus_ctrl (
	input  logic                     clk,
	input  logic                     RSTn,
	input  cpu_board_pkg::cpu_req_t  main_req,
	input  logic                     bsl,
	input  cpu_board_pkg::data_t     db_in,
	output cpu_board_pkg::rom_addr_t rom_fixed_addr,
	output cpu_board_pkg::rom_addr_t rom_banked_addr,
	input  cpu_board_pkg::data_t     rom_fixed_data,
	input  cpu_board_pkg::data_t     rom_banked_data,
	output cpu_board_pkg::cpu_req_t  shm_req,
	input  cpu_board_pkg::cpu_rsp_t  shm_rsp,
	output cpu_board_pkg::ext_bus_t  ext_bus,
	output cpu_board_pkg::cpu_rsp_t  main_rsp
);
	import cpu_board_pkg::*;

	addr_t       a;
	tgt_t        tgt_d;
	periph_sel_t sel_d;
	// access held from the strobe on
	cpu_req_t    req_q;
	logic        bsl_q;
	sram_addr_t  shm_addr;
	logic        shm_stb_q;
	periph_sel_t sel_q;
	// read pipeline, stage 1 and 2
	logic        vld1_q;
	logic        vld2_q;
	tgt_t        tgt1_q;
	tgt_t        tgt2_q;
	data_t       db_q;
	data_t       rd_byte;
	logic        rsp_vld_q;
	data_t       rsp_data_q;

	assign a = main_req.addr;

	//**********************************************************
	// address decode
	//**********************************************************
	always_comb begin
		if (a <= SHARED_TOP)
			tgt_d = TGT_SHM;
		else if (a < BANKED_BASE)
			tgt_d = TGT_EXT;
		else if (a < FIXED_BASE)
			tgt_d = TGT_BANKED;
		else
			tgt_d = TGT_FIXED;
		// peripheral windows
		sel_d.map   = (a >= MAP_BASE) && (a < BACK1_BASE);
		sel_d.back1 = (a >= BACK1_BASE) && (a < BACK2_BASE);
		sel_d.back2 = (a >= BACK2_BASE) && (a < OBJ_BASE);
		sel_d.obj   = (a >= OBJ_BASE) && (a < IO_BASE);
		sel_d.io    = (a >= IO_BASE) && (a < PL_BASE);
		sel_d.pl    = (a >= PL_BASE) && (a < BANKED_BASE);
	end

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			vld1_q    <= 1'b0;
			vld2_q    <= 1'b0;
			tgt1_q    <= TGT_SHM;
			tgt2_q    <= TGT_SHM;
			sel_q     <= '0;
			shm_stb_q <= 1'b0;
			rsp_vld_q <= 1'b0;
		end else begin
			// rom writes fall through, only reads go down the pipe
			vld1_q    <= main_req.strobe && main_req.rd;
			tgt1_q    <= tgt_d;
			sel_q     <= main_req.strobe ? sel_d : '0;
			shm_stb_q <= main_req.strobe && (tgt_d == TGT_SHM);
			vld2_q    <= vld1_q;
			tgt2_q    <= tgt1_q;
			// shared ram returns on its own, 2 or 3 edges
			rsp_vld_q <= (vld2_q && (tgt2_q != TGT_SHM)) || shm_rsp.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (main_req.strobe) begin
			req_q <= main_req;
			bsl_q <= bsl;
		end
		// db_in taken at the end of the select cycle
		if (|sel_q)
			db_q <= db_in;
		rsp_data_q <= shm_rsp.valid ? shm_rsp.rdata : rd_byte;
	end

	// return byte by target
	always_comb begin
		case (tgt2_q)
			TGT_BANKED: rd_byte = rom_banked_data;
			TGT_FIXED:  rd_byte = rom_fixed_data;
			TGT_EXT:    rd_byte = db_q;
			default:    rd_byte = BUS_IDLE;
		endcase
	end

	// bsl picks the 16K half of the banked rom
	assign rom_fixed_addr  = req_q.addr[14:0];
	assign rom_banked_addr = {bsl_q, req_q.addr[13:0]};

	assign shm_addr = req_q.addr[12:0];
	assign shm_req  = '{strobe: shm_stb_q, rd: req_q.rd, addr: addr_t'(shm_addr),
		wdata: req_q.wdata};
	assign ext_bus  = '{sel: sel_q, rd: req_q.rd, addr: req_q.addr[14:0],
		wdata: req_q.wdata};
	assign main_rsp = '{valid: rsp_vld_q, rdata: rsp_data_q};

endmodule

// ==== design/sub_bus_ctrl.sv ====
`timescale 1ns/1ps
//**********************************************************
// sub cpu bus control
// decode, rom bank register, irq strobes and read return
//**********************************************************
module sub_bus_ctrl (
	input  logic                     clk,
	input  logic                     RSTn,
	input  cpu_board_pkg::cpu_req_t  sub_req,
	output cpu_board_pkg::rom_addr_t rom_fixed_addr,
	output cpu_board_pkg::rom_addr_t rom_banked_addr,
	input  cpu_board_pkg::data_t     rom_fixed_data,
	input  cpu_board_pkg::data_t     rom_banked_data,
	output cpu_board_pkg::cpu_req_t  shm_req,
	input  cpu_board_pkg::cpu_rsp_t  shm_rsp,
	output logic                     main_irq_set,
	output logic                     sub_irq_clr,
	output cpu_board_pkg::cpu_rsp_t  sub_rsp
);
	import cpu_board_pkg::*;

	addr_t      a;
	tgt_t       tgt_d;
	logic       wr_stb;
	logic       bank_wr;
	logic       bank_q;
	cpu_req_t   req_q;
	sram_addr_t shm_addr;
	logic       shm_stb_q;
	logic       vld1_q;
	logic       vld2_q;
	tgt_t       tgt1_q;
	tgt_t       tgt2_q;
	data_t      rd_byte;
	logic       rsp_vld_q;
	data_t      rsp_data_q;

	assign a      = sub_req.addr;
	assign wr_stb = sub_req.strobe && !sub_req.rd;

	// 2000..3FFF holds only write windows, reads float
	always_comb begin
		if (a <= SHARED_TOP)
			tgt_d = TGT_SHM;
		else if (a < BANKED_BASE)
			tgt_d = TGT_EXT;
		else if (a < FIXED_BASE)
			tgt_d = TGT_BANKED;
		else
			tgt_d = TGT_FIXED;
	end

	// window strobes, registered in the interrupt block
	assign main_irq_set = wr_stb && (a >= SUB_MAIN_IRQ_BASE) && (a < SUB_IRQ_CLR_BASE);
	assign sub_irq_clr  = wr_stb && (a >= SUB_IRQ_CLR_BASE) && (a < SUB_BANK_BASE);
	assign bank_wr      = wr_stb && (a >= SUB_BANK_BASE) && (a < SUB_BANK_BASE + SUB_WIN_SIZE);

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			bank_q    <= 1'b0;
			vld1_q    <= 1'b0;
			vld2_q    <= 1'b0;
			tgt1_q    <= TGT_SHM;
			tgt2_q    <= TGT_SHM;
			shm_stb_q <= 1'b0;
			rsp_vld_q <= 1'b0;
		end else begin
			// bank bit is data line 0
			if (bank_wr)
				bank_q <= sub_req.wdata[0];
			vld1_q    <= sub_req.strobe && sub_req.rd;
			tgt1_q    <= tgt_d;
			shm_stb_q <= sub_req.strobe && (tgt_d == TGT_SHM);
			vld2_q    <= vld1_q;
			tgt2_q    <= tgt1_q;
			rsp_vld_q <= (vld2_q && (tgt2_q != TGT_SHM)) || shm_rsp.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sub_req.strobe)
			req_q <= sub_req;
		rsp_data_q <= shm_rsp.valid ? shm_rsp.rdata : rd_byte;
	end

	always_comb begin
		case (tgt2_q)
			TGT_BANKED: rd_byte = rom_banked_data;
			TGT_FIXED:  rd_byte = rom_fixed_data;
			default:    rd_byte = BUS_IDLE;
		endcase
	end

	assign rom_fixed_addr  = req_q.addr[14:0];
	assign rom_banked_addr = {bank_q, req_q.addr[13:0]};

	assign shm_addr = req_q.addr[12:0];
	assign shm_req  = '{strobe: shm_stb_q, rd: req_q.rd, addr: addr_t'(shm_addr),
		wdata: req_q.wdata};
	assign sub_rsp  = '{valid: rsp_vld_q, rdata: rsp_data_q};

endmodule

// ==== design/shared_ram_arbiter.sv ====
`timescale 1ns/1ps
//**********************************************************
// shared work ram, 8K x 8, one port
// sub has priority, a colliding main access waits one edge
//**********************************************************
module shared_ram_arbiter (
	input  logic                    clk,
	input  logic                    RSTn,
	input  cpu_board_pkg::cpu_req_t main_shm_req,
	input  cpu_board_pkg::cpu_req_t sub_shm_req,
	output cpu_board_pkg::cpu_rsp_t main_shm_rsp,
	output cpu_board_pkg::cpu_rsp_t sub_shm_rsp
);
	import cpu_board_pkg::*;

	typedef enum logic {
		ARB_IDLE,
		ARB_MAIN_PEND
	} arb_state_t;

	arb_state_t state;
	arb_state_t state_nx;
	// main access parked during a collision
	cpu_req_t   main_hold;
	cpu_req_t   port_req;
	logic       sub_go;
	logic       main_want;
	logic       main_go;
	sram_addr_t port_addr;
	data_t      mem [SHARED_RAM_WORDS];
	data_t      ram_q;
	logic       main_vld_q;
	logic       sub_vld_q;

	//**********************************************************
	// port arbitration
	//**********************************************************
	always_comb begin
		sub_go    = sub_shm_req.strobe;
		main_want = main_shm_req.strobe || (state == ARB_MAIN_PEND);
		main_go   = main_want && !sub_go;
		if (sub_go)
			port_req = sub_shm_req;
		else if (state == ARB_MAIN_PEND)
			port_req = main_hold;
		else
			port_req = main_shm_req;
		// main stays parked while sub holds the port
		if (sub_go && main_want)
			state_nx = ARB_MAIN_PEND;
		else
			state_nx = ARB_IDLE;
	end

	assign port_addr = port_req.addr[12:0];

	always_ff @(posedge clk) begin
		if (main_shm_req.strobe)
			main_hold <= main_shm_req;
	end

	// read-before-write ram
	always_ff @(posedge clk) begin
		if ((sub_go || main_go) && !port_req.rd)
			mem[port_addr] <= port_req.wdata;
		ram_q <= mem[port_addr];
	end

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			state      <= ARB_IDLE;
			main_vld_q <= 1'b0;
			sub_vld_q  <= 1'b0;
		end else begin
			state      <= state_nx;
			sub_vld_q  <= sub_go && sub_shm_req.rd;
			main_vld_q <= main_go && port_req.rd;
		end
	end

	// one data path, valid tells the owner
	assign main_shm_rsp = '{valid: main_vld_q, rdata: ram_q};
	assign sub_shm_rsp  = '{valid: sub_vld_q, rdata: ram_q};

endmodule

// ==== design/cpu_board.sv ====
`timescale 1ns/1ps
//**********************************************************
// two-cpu board glue logic, top level
//**********************************************************
module cpu_board (
	input  logic                     clk,
	input  logic                     RSTn,
	input  cpu_board_pkg::cpu_req_t  main_req,
	input  cpu_board_pkg::cpu_req_t  sub_req,
	output cpu_board_pkg::cpu_rsp_t  main_rsp,
	output cpu_board_pkg::cpu_rsp_t  sub_rsp,
	input  logic                     bsl,
	output cpu_board_pkg::ext_bus_t  ext_bus,
	input  cpu_board_pkg::data_t     db_in,
	input  cpu_board_pkg::rom_load_t rom_load,
	input  logic                     vblank,
	input  logic                     ims,
	input  logic                     nmi_ack,
	input  logic                     irq_ack,
	input  logic                     firq_ack,
	input  logic                     sub_irq_set,
	output cpu_board_pkg::main_irq_t main_irq,
	output logic                     sub_irq_n
);
	import cpu_board_pkg::*;

	// rom pairs
	rom_addr_t main_fixed_addr;
	rom_addr_t main_banked_addr;
	data_t     main_fixed_data;
	data_t     main_banked_data;
	rom_addr_t sub_fixed_addr;
	rom_addr_t sub_banked_addr;
	data_t     sub_fixed_data;
	data_t     sub_banked_data;
	// shared ram
	cpu_req_t  main_shm_req;
	cpu_req_t  sub_shm_req;
	cpu_rsp_t  main_shm_rsp;
	cpu_rsp_t  sub_shm_rsp;
	// sub side interrupt strobes
	logic      main_irq_set;
	logic      sub_irq_clr;

	main_bus_ctrl i_main_bus_ctrl (
		.clk             (clk),
		.RSTn            (RSTn),
		.main_req        (main_req),
		.bsl             (bsl),
		.db_in           (db_in),
		.rom_fixed_addr  (main_fixed_addr),
		.rom_banked_addr (main_banked_addr),
		.rom_fixed_data  (main_fixed_data),
		.rom_banked_data (main_banked_data),
		.shm_req         (main_shm_req),
		.shm_rsp         (main_shm_rsp),
		.ext_bus         (ext_bus),
		.main_rsp        (main_rsp)
	);

	sub_bus_ctrl i_sub_bus_ctrl (
		.clk             (clk),
		.RSTn            (RSTn),
		.sub_req         (sub_req),
		.rom_fixed_addr  (sub_fixed_addr),
		.rom_banked_addr (sub_banked_addr),
		.rom_fixed_data  (sub_fixed_data),
		.rom_banked_data (sub_banked_data),
		.shm_req         (sub_shm_req),
		.shm_rsp         (sub_shm_rsp),
		.main_irq_set    (main_irq_set),
		.sub_irq_clr     (sub_irq_clr),
		.sub_rsp         (sub_rsp)
	);

	// cs bit 0 loads the main pair, bit 1 the sub pair
	banked_rom #(.LOAD_CS(0)) i_main_rom (
		.clk         (clk),
		.rom_load    (rom_load),
		.fixed_addr  (main_fixed_addr),
		.banked_addr (main_banked_addr),
		.fixed_data  (main_fixed_data),
		.banked_data (main_banked_data)
	);

	banked_rom #(.LOAD_CS(1)) i_sub_rom (
		.clk         (clk),
		.rom_load    (rom_load),
		.fixed_addr  (sub_fixed_addr),
		.banked_addr (sub_banked_addr),
		.fixed_data  (sub_fixed_data),
		.banked_data (sub_banked_data)
	);

	shared_ram_arbiter i_shared_ram_arbiter (
		.clk          (clk),
		.RSTn         (RSTn),
		.main_shm_req (main_shm_req),
		.sub_shm_req  (sub_shm_req),
		.main_shm_rsp (main_shm_rsp),
		.sub_shm_rsp  (sub_shm_rsp)
	);

	interrupt_ctrl i_interrupt_ctrl (
		.clk          (clk),
		.RSTn         (RSTn),
		.vblank       (vblank),
		.ims          (ims),
		.nmi_ack      (nmi_ack),
		.irq_ack      (irq_ack),
		.firq_ack     (firq_ack),
		.main_irq_set (main_irq_set),
		.sub_irq_set  (sub_irq_set),
		.sub_irq_clr  (sub_irq_clr),
		.main_irq     (main_irq),
		.sub_irq_n    (sub_irq_n)
	);

endmodule

// ==== testbench/cpu_board_checks.svh ====
//**********************************************************
// testbench helpers of the cpu board
// compare tasks, bus drivers and response collection
//**********************************************************
`ifndef CPU_BOARD_CHECKS_SVH
`define CPU_BOARD_CHECKS_SVH

//**********************************************************
// failure reporting
//**********************************************************
task automatic fail_run();
	$display("TEST FAILED");
	$fatal(1, "run stopped at the first error");
endtask

// failures that are not a value mismatch
task automatic report_failure(input string what);
	$display("ERROR at %0t: %s", $time, what);
	fail_run();
endtask

//**********************************************************
// compare tasks, one per result type
//**********************************************************
task automatic check_data(input string name, input data_t got, input data_t exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		fail_run();
	end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		fail_run();
	end
endtask

task automatic check_sel(input string name, input periph_sel_t got, input periph_sel_t exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
		fail_run();
	end
endtask

task automatic check_irq(input string name, input main_irq_t got, input main_irq_t exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
		fail_run();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
		fail_run();
	end
endtask

// latency in edges after the strobe edge
// negative when nothing came
task automatic check_latency(input string name, input int got, input int exp);
	if (got < 0)
		report_failure($sformatf("%s: no valid response within 3 cycles", name));
	else if (got != exp) begin
		$display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
		fail_run();
	end
endtask

//**********************************************************
// bus drivers
//**********************************************************
function automatic cpu_req_t make_req(input logic rd, input addr_t a, input data_t d);
	return '{strobe: 1'b1, rd: rd, addr: a, wdata: d};
endfunction

// every single-cycle strobe ends here
task automatic drop_strobes();
	main_req.strobe = 1'b0;
	sub_req.strobe  = 1'b0;
	nmi_ack         = 1'b0;
	irq_ack         = 1'b0;
	firq_ack        = 1'b0;
	sub_irq_set     = 1'b0;
endtask

// one access per cpu on the falling edge
task automatic drive_access(input cpu_req_t mreq, input cpu_req_t sreq);
	@(negedge clk);
	main_req = mreq;
	sub_req  = sreq;
endtask

// watch both response ports for 4 cycles
// only one valid cycle per port is allowed
// latency -1 when none
task automatic collect_rsp(output int m_lat, output data_t m_data,
	output int s_lat, output data_t s_data);
	m_lat  = -1;
	s_lat  = -1;
	m_data = '0;
	s_data = '0;
	for (int k = 1; k <= 4; k++) begin
		@(negedge clk);
		drop_strobes();
		if (main_rsp.valid) begin
			if (m_lat >= 0)
				report_failure("main_rsp valid in more than one cycle");
			m_lat  = k - 1;
			m_data = main_rsp.rdata;
		end
		if (sub_rsp.valid) begin
			if (s_lat >= 0)
				report_failure("sub_rsp valid in more than one cycle");
			s_lat  = k - 1;
			s_data = sub_rsp.rdata;
		end
	end
endtask

// single read answered two edges after the strobe
task automatic bus_read(input logic on_sub, input addr_t a, input data_t exp);
	int    m_lat;
	int    s_lat;
	data_t m_data;
	data_t s_data;
	if (on_sub)
		drive_access('0, make_req(1'b1, a, '0));
	else
		drive_access(make_req(1'b1, a, '0), '0);
	collect_rsp(m_lat, m_data, s_lat, s_data);
	if (on_sub) begin
		if (m_lat >= 0)
			report_failure("main_rsp valid without a main read");
		check_latency("sub_rsp latency", s_lat, 2);
		check_data("sub_rsp.rdata", s_data, exp);
	end else begin
		if (s_lat >= 0)
			report_failure("sub_rsp valid without a sub read");
		check_latency("main_rsp latency", m_lat, 2);
		check_data("main_rsp.rdata", m_data, exp);
	end
endtask

// writes give no response on either port
task automatic bus_write(input logic on_sub, input addr_t a, input data_t d);
	int    m_lat;
	int    s_lat;
	data_t m_data;
	data_t s_data;
	if (on_sub)
		drive_access('0, make_req(1'b0, a, d));
	else
		drive_access(make_req(1'b0, a, d), '0);
	collect_rsp(m_lat, m_data, s_lat, s_data);
	if (m_lat >= 0 || s_lat >= 0)
		report_failure($sformatf("write to %h produced a read response", a));
endtask

// interrupt lines one and two cycles after the current edge
task automatic watch_irq_lines(input main_irq_t exp1, input logic sub1,
	input main_irq_t exp2, input logic sub2);
	@(negedge clk);
	drop_strobes();
	check_irq("main_irq", main_irq, exp1);
	check_bit("sub_irq_n", sub_irq_n, sub1);
	@(negedge clk);
	check_irq("main_irq", main_irq, exp2);
	check_bit("sub_irq_n", sub_irq_n, sub2);
endtask

`endif

// ==== testbench/tb_cpu_board.sv ====
`timescale 1ns/1ps
//**********************************************************
// testbench of the two-cpu board
// loads the roms, then runs directed tests on every bus path
//**********************************************************
module tb_cpu_board;
	import cpu_board_pkg::*;

	localparam int        CLK_HALF     = 20;
	localparam int        RESET_CYCLES = 5;
	// bytes loaded per rom, half in each 16K
	localparam int        ROM_SPAN     = 32;
	localparam rom_addr_t ROM_OFS      = 15'h0120;
	// tests take about 900 cycles, loads and 5-cycle accesses
	localparam int        MAX_CYCLES   = 4000;
	localparam logic      ON_MAIN      = 1'b0;
	localparam logic      ON_SUB       = 1'b1;
	localparam main_irq_t IRQ_IDLE     = '{nmi_n: 1'b1, irq_n: 1'b1, firq_n: 1'b1};
	localparam main_irq_t NMI_LOW      = '{nmi_n: 1'b0, irq_n: 1'b1, firq_n: 1'b1};
	localparam main_irq_t IRQ_LOW      = '{nmi_n: 1'b1, irq_n: 1'b0, firq_n: 1'b1};
	localparam main_irq_t FIRQ_LOW     = '{nmi_n: 1'b1, irq_n: 1'b1, firq_n: 1'b0};

	logic        clk = 1'b0;
	logic        RSTn;
	cpu_req_t    main_req;
	cpu_req_t    sub_req;
	cpu_rsp_t    main_rsp;
	cpu_rsp_t    sub_rsp;
	logic        bsl;
	ext_bus_t    ext_bus;
	data_t       db_in;
	rom_load_t   rom_load;
	logic        vblank;
	logic        ims;
	logic        nmi_ack;
	logic        irq_ack;
	logic        firq_ack;
	logic        sub_irq_set;
	main_irq_t   main_irq;
	logic        sub_irq_n;
	logic [15:0] lfsr_state = 16'd4;
	int          cycle_cnt  = 0;
	// 0 main fixed, 1 main banked, 2 sub fixed, 3 sub banked
	data_t       ref_rom [4][ROM_SPAN];

	`include "cpu_board_checks.svh"

	always #(CLK_HALF) clk = ~clk;

	cpu_board i_cpu_board (
		.clk         (clk),
		.RSTn        (RSTn),
		.main_req    (main_req),
		.sub_req     (sub_req),
		.main_rsp    (main_rsp),
		.sub_rsp     (sub_rsp),
		.bsl         (bsl),
		.ext_bus     (ext_bus),
		.db_in       (db_in),
		.rom_load    (rom_load),
		.vblank      (vblank),
		.ims         (ims),
		.nmi_ack     (nmi_ack),
		.irq_ack     (irq_ack),
		.firq_ack    (firq_ack),
		.sub_irq_set (sub_irq_set),
		.main_irq    (main_irq),
		.sub_irq_n   (sub_irq_n)
	);

	// run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("ERROR: no end of test after %0d cycles", MAX_CYCLES);
			fail_run();
		end
	end

	//**********************************************************
	// reference rom images
	//**********************************************************
	// fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one step per bit taken
	task automatic rand_byte(output data_t b);
		b = '0;
		for (int n = 0; n < 8; n++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	// rom address of image byte i, upper half lands in the second 16K
	function automatic rom_addr_t rom_offset(input int i);
		if (i < ROM_SPAN / 2)
			return rom_addr_t'(ROM_OFS + i);
		return rom_addr_t'(15'h4000 + ROM_OFS + i - ROM_SPAN / 2);
	endfunction

	task automatic fill_reference();
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i < ROM_SPAN; i++)
				rand_byte(ref_rom[r][i]);
		end
	endtask

	// cs bit per pair, load address bit 15 for the banked rom
	task automatic load_rom(input int r);
		for (int i = 0; i < ROM_SPAN; i++) begin
			@(negedge clk);
			rom_load.wr   = 1'b1;
			rom_load.cs   = (r < 2) ? 2'b01 : 2'b10;
			rom_load.addr = {r[0], rom_offset(i)};
			rom_load.data = ref_rom[r][i];
		end
		@(negedge clk);
		rom_load = '0;
	endtask

	//**********************************************************
	// directed tests
	//**********************************************************
	task automatic test_reset();
		check_irq("main_irq", main_irq, IRQ_IDLE);
		check_bit("sub_irq_n", sub_irq_n, 1'b1);
		check_bit("main_rsp.valid", main_rsp.valid, 1'b0);
		check_bit("sub_rsp.valid", sub_rsp.valid, 1'b0);
		check_sel("ext_bus.sel", ext_bus.sel, '0);
	endtask

	task automatic test_roms();
		rom_addr_t ra;
		for (int r = 0; r < 4; r++)
			load_rom(r);
		for (int i = 0; i < ROM_SPAN; i++) begin
			ra = rom_offset(i);
			bus_read(ON_MAIN, FIXED_BASE | addr_t'(ra), ref_rom[0][i]);
			// bsl is rom address bit 14 of the banked rom
			bsl = ra[14];
			bus_read(ON_MAIN, BANKED_BASE | addr_t'(ra[13:0]), ref_rom[1][i]);
			bus_read(ON_SUB, FIXED_BASE | addr_t'(ra), ref_rom[2][i]);
		end
		bsl = 1'b0;
		// bank register 0 out of reset
		for (int i = 0; i < ROM_SPAN / 2; i++) begin
			ra = rom_offset(i);
			bus_read(ON_SUB, BANKED_BASE | addr_t'(ra[13:0]), ref_rom[3][i]);
		end
		bus_write(ON_SUB, SUB_BANK_BASE, 8'h01);
		for (int i = ROM_SPAN / 2; i < ROM_SPAN; i++) begin
			ra = rom_offset(i);
			bus_read(ON_SUB, BANKED_BASE | addr_t'(ra[13:0]), ref_rom[3][i]);
		end
	endtask

	task automatic test_shared_ram();
		int    m_lat;
		int    s_lat;
		data_t m_data;
		data_t s_data;
		bus_write(ON_MAIN, 16'h0123, 8'h3C);
		bus_read(ON_SUB, 16'h0123, 8'h3C);
		bus_write(ON_SUB, SHARED_TOP, 8'hA5);
		bus_read(ON_MAIN, SHARED_TOP, 8'hA5);
		// sub read and main write together, sub sees the old byte
		bus_write(ON_MAIN, 16'h0040, 8'h5A);
		drive_access(make_req(1'b0, 16'h0040, 8'hC3), make_req(1'b1, 16'h0040, '0));
		collect_rsp(m_lat, m_data, s_lat, s_data);
		if (m_lat >= 0)
			report_failure("main write in a collision produced a read response");
		check_latency("sub_rsp latency", s_lat, 2);
		check_data("sub_rsp.rdata", s_data, 8'h5A);
		bus_read(ON_MAIN, 16'h0040, 8'hC3);
		// main read deferred behind a sub write
		bus_write(ON_SUB, 16'h0800, 8'h77);
		drive_access(make_req(1'b1, 16'h0800, '0), make_req(1'b0, 16'h0801, 8'h11));
		collect_rsp(m_lat, m_data, s_lat, s_data);
		if (s_lat >= 0)
			report_failure("sub write in a collision produced a read response");
		check_latency("main_rsp latency", m_lat, 3);
		check_data("main_rsp.rdata", m_data, 8'h77);
		bus_read(ON_SUB, 16'h0801, 8'h11);
	endtask

	function automatic addr_t window_addr(input int w);
		case (w)
			0:       return MAP_BASE + 16'h0011;
			1:       return BACK1_BASE + 16'h07FF;
			2:       return BACK2_BASE;
			3:       return OBJ_BASE + 16'h01FF;
			4:       return IO_BASE + 16'h0100;
			default: return PL_BASE + 16'h03FF;
		endcase
	endfunction

	function automatic periph_sel_t window_sel(input int w);
		periph_sel_t s;
		s = '0;
		case (w)
			0:       s.map   = 1'b1;
			1:       s.back1 = 1'b1;
			2:       s.back2 = 1'b1;
			3:       s.obj   = 1'b1;
			4:       s.io    = 1'b1;
			default: s.pl    = 1'b1;
		endcase
		return s;
	endfunction

	task automatic test_periph();
		addr_t a;
		data_t wd;
		for (int w = 0; w < 6; w++) begin
			a  = window_addr(w);
			wd = data_t'(8'h40 + w);
			drive_access(make_req(1'b0, a, wd), '0);
			// select only in the cycle after the strobe
			@(negedge clk);
			drop_strobes();
			check_sel("ext_bus.sel", ext_bus.sel, window_sel(w));
			check_bit("ext_bus.rd", ext_bus.rd, 1'b0);
			check_addr("ext_bus.addr", addr_t'(ext_bus.addr), {1'b0, a[14:0]});
			check_data("ext_bus.wdata", ext_bus.wdata, wd);
			@(negedge clk);
			check_sel("ext_bus.sel", ext_bus.sel, '0);
			repeat (2) @(negedge clk);
		end
		// io read, db_in taken at the end of the select cycle
		drive_access(make_req(1'b1, IO_BASE + 16'h0004, '0), '0);
		@(negedge clk);
		drop_strobes();
		check_sel("ext_bus.sel", ext_bus.sel, window_sel(4));
		check_bit("ext_bus.rd", ext_bus.rd, 1'b1);
		db_in = 8'hA6;
		@(negedge clk);
		db_in = 8'h3C;
		check_bit("main_rsp.valid", main_rsp.valid, 1'b0);
		@(negedge clk);
		check_bit("main_rsp.valid", main_rsp.valid, 1'b1);
		check_data("main_rsp.rdata", main_rsp.rdata, 8'hA6);
		@(negedge clk);
		db_in = '0;
		// write-only window reads float
		bus_read(ON_SUB, SUB_MAIN_IRQ_BASE, BUS_IDLE);
	endtask

	task automatic test_interrupts();
		@(negedge clk);
		vblank = 1'b1;
		watch_irq_lines(IRQ_IDLE, 1'b1, NMI_LOW, 1'b1);
		nmi_ack = 1'b1;
		watch_irq_lines(NMI_LOW, 1'b1, IRQ_IDLE, 1'b1);
		vblank = 1'b0;
		// sub cpu raises the main irq
		sub_req = make_req(1'b0, SUB_MAIN_IRQ_BASE + 16'h0010, 8'h00);
		watch_irq_lines(IRQ_IDLE, 1'b1, IRQ_LOW, 1'b1);
		irq_ack = 1'b1;
		watch_irq_lines(IRQ_LOW, 1'b1, IRQ_IDLE, 1'b1);
		ims = 1'b1;
		watch_irq_lines(IRQ_IDLE, 1'b1, FIRQ_LOW, 1'b1);
		firq_ack = 1'b1;
		watch_irq_lines(FIRQ_LOW, 1'b1, IRQ_IDLE, 1'b1);
		ims = 1'b0;
		// sub irq, cleared by the sub itself
		sub_irq_set = 1'b1;
		watch_irq_lines(IRQ_IDLE, 1'b1, IRQ_IDLE, 1'b0);
		sub_req = make_req(1'b0, SUB_IRQ_CLR_BASE, 8'h00);
		watch_irq_lines(IRQ_IDLE, 1'b0, IRQ_IDLE, 1'b1);
		// set and clear on the same edge
		repeat (3) @(negedge clk);
		sub_irq_set = 1'b1;
		sub_req     = make_req(1'b0, SUB_IRQ_CLR_BASE + 16'h0001, 8'h00);
		watch_irq_lines(IRQ_IDLE, 1'b1, IRQ_IDLE, 1'b1);
		repeat (3) @(negedge clk);
		irq_ack = 1'b1;
		sub_req = make_req(1'b0, SUB_MAIN_IRQ_BASE, 8'h00);
		watch_irq_lines(IRQ_IDLE, 1'b1, IRQ_IDLE, 1'b1);
	endtask

	//**********************************************************
	// test sequence
	//**********************************************************
	initial begin
		RSTn     = 1'b0;
		main_req = '0;
		sub_req  = '0;
		bsl      = 1'b0;
		db_in    = '0;
		rom_load = '0;
		vblank   = 1'b0;
		ims      = 1'b0;
		drop_strobes();
		fill_reference();
		repeat (RESET_CYCLES) @(negedge clk);
		RSTn = 1'b1;
		@(negedge clk);
		test_reset();
		test_roms();
		test_shared_ram();
		test_periph();
		test_interrupts();
		repeat (2) @(negedge clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== cpu_board.f ====
+incdir+testbench
design/cpu_board_pkg.sv
design/interrupt_ctrl.sv
design/banked_rom.sv
design/main_bus_ctrl.sv
design/sub_bus_ctrl.sv
design/shared_ram_arbiter.sv
design/cpu_board.sv
testbench/tb_cpu_board.sv

// ==== Bender.yml ====
package:
  name: cpu_board

sources:
  # rtl, package first
  - files:
      - design/cpu_board_pkg.sv
      - design/interrupt_ctrl.sv
      - design/banked_rom.sv
      - design/main_bus_ctrl.sv
      - design/sub_bus_ctrl.sv
      - design/shared_ram_arbiter.sv
      - design/cpu_board.sv
  # testbench, top module tb_cpu_board
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_cpu_board.sv
